//--- hdl/tlb_pkg.sv
package tlb_pkg;

  // page size exponent that marks a 4 MB page
  localparam logic [5:0] PS_4M = 6'd22;

  // key compared by every match entry
  // vppn covers va[31:13], one pair of 4 KB pages
  typedef struct packed {
    logic [18:0] vppn;
    logic [9:0]  asid;
    // global entry ignores the asid
    logic        g;
    logic [5:0]  ps;
    // entry exists
    logic        e;
  } tlb_key_t;

  // one half of a page pair
  typedef struct packed {
    logic [19:0] ppn;
    // page valid
    logic        v;
    // page dirty, writes allowed
    logic        d;
    // privilege level
    logic [1:0]  plv;
  } tlb_page_t;

  // operation strobe, idle at none
  typedef enum logic [1:0] {
    TLB_OP_NONE    = 2'd0,
    TLB_OP_FILL    = 2'd1,
    TLB_OP_INV_ALL = 2'd2
  } tlb_op_e;

endpackage

//--- hdl/tlb_match_entry.sv
`timescale 1ns/1ns

module tlb_match_entry (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic [18:0]     vppn_i,
  input  logic [9:0]      asid_i,
  input  logic            update_i,
  input  tlb_pkg::tlb_key_t update_key_i,
  output logic            match_o,
  output logic [5:0]      ps_o
);

  import tlb_pkg::*;

  // stored key, only e has a reset value
  logic        e_q;
  logic [18:0] vppn_q;
  logic [9:0]  asid_q;
  logic        g_q;
  logic [5:0]  ps_q;
  // 4 MB flag kept beside the key, keeps the compare off the ps decode
  logic        is_4m_q;

  logic match_high9;
  logic match_low10;
  logic match_asid;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      e_q <= 1'b0;
    end else if (update_i) begin
      e_q <= update_key_i.e;
    end
  end

  always_ff @(posedge clk) begin
    if (update_i) begin
      vppn_q  <= update_key_i.vppn;
      asid_q  <= update_key_i.asid;
      g_q     <= update_key_i.g;
      ps_q    <= update_key_i.ps;
      is_4m_q <= (update_key_i.ps == PS_4M);
    end
  end

  // split compare, upper part always counts
  assign match_high9 = (vppn_q[18:10] == vppn_i[18:10]);
  assign match_low10 = (vppn_q[9:0] == vppn_i[9:0]);
  assign match_asid  = (asid_q == asid_i);

  // low bits ignored for 4 MB, asid ignored for global
  assign match_o = e_q && match_high9 && (is_4m_q || match_low10) && (g_q || match_asid);
  assign ps_o    = ps_q;

endmodule

//--- hdl/tlb_hit_encoder.sv
`timescale 1ns/1ns

module tlb_hit_encoder #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic [NUM_ENTRIES-1:0]         match_vec_i,
  output logic                           hit_o,
  output logic [$clog2(NUM_ENTRIES)-1:0] idx_o,
  output logic                           multi_hit_o
);

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  // vector with its lowest set bit removed
  logic [NUM_ENTRIES-1:0] rest_vec;

  // any entry matched
  assign hit_o = |match_vec_i;

  // lowest set index wins
  // scan from the top so the last write is the lowest bit
  always_comb begin
    idx_o = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (match_vec_i[i]) begin
        idx_o = IDX_W'(i);
      end
    end
  end

  // clear the lowest set bit, anything left means two or more matches
  assign rest_vec = match_vec_i & (match_vec_i - NUM_ENTRIES'(1));

  // software wrote overlapping entries
  assign multi_hit_o = |rest_vec;

endmodule

//--- hdl/tlb_page_store.sv
`timescale 1ns/1ns

module tlb_page_store #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  logic                           we_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0] wr_idx_i,
  input  tlb_pkg::tlb_page_t             page0_i,
  input  tlb_pkg::tlb_page_t             page1_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0] rd_idx_i,
  output tlb_pkg::tlb_page_t             page0_o,
  output tlb_pkg::tlb_page_t             page1_o
);

  import tlb_pkg::*;

  // page pair payload, no reset
  tlb_page_t page0_q [NUM_ENTRIES];
  tlb_page_t page1_q [NUM_ENTRIES];
  // valid bits held apart so reset can clear them
  logic [NUM_ENTRIES-1:0] v0_q;
  logic [NUM_ENTRIES-1:0] v1_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v0_q <= '0;
      v1_q <= '0;
    end else if (we_i) begin
      v0_q[wr_idx_i] <= page0_i.v;
      v1_q[wr_idx_i] <= page1_i.v;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      page0_q[wr_idx_i] <= page0_i;
      page1_q[wr_idx_i] <= page1_i;
    end
  end

  // combinational read at the hit index
  always_comb begin
    page0_o   = page0_q[rd_idx_i];
    page1_o   = page1_q[rd_idx_i];
    // valid comes from the reset copy
    page0_o.v = v0_q[rd_idx_i];
    page1_o.v = v1_q[rd_idx_i];
  end

endmodule

//--- hdl/tlb_ctrl.sv
`timescale 1ns/1ns

module tlb_ctrl #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  tlb_pkg::tlb_op_e               op_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0] fill_idx_i,
  input  tlb_pkg::tlb_key_t              fill_key_i,
  input  tlb_pkg::tlb_page_t             fill_page0_i,
  input  tlb_pkg::tlb_page_t             fill_page1_i,
  output logic [NUM_ENTRIES-1:0]         entry_update_o,
  output tlb_pkg::tlb_key_t              update_key_o,
  output logic                           page_we_o,
  output logic [$clog2(NUM_ENTRIES)-1:0] page_idx_o,
  output tlb_pkg::tlb_page_t             page0_o,
  output tlb_pkg::tlb_page_t             page1_o
);

  import tlb_pkg::*;

  // page data and index always follow the fill ports
  assign page_idx_o = fill_idx_i;
  assign page0_o    = fill_page0_i;
  assign page1_o    = fill_page1_i;

  // decode within the strobe cycle
  // entries latch at the closing edge
  always_comb begin
    entry_update_o = '0;
    update_key_o   = fill_key_i;
    page_we_o      = 1'b0;
    case (op_i)
      TLB_OP_FILL: begin
        // one entry takes the new key and its page pair
        entry_update_o[fill_idx_i] = 1'b1;
        page_we_o                  = 1'b1;
      end
      TLB_OP_INV_ALL: begin
        // all entries take a key that does not exist
        entry_update_o = '1;
        update_key_o.e = 1'b0;
      end
      default: begin
        // idle and the unused code change nothing
        entry_update_o = '0;
      end
    endcase
  end

endmodule

//--- hdl/tlb_lookup_stage.sv
`timescale 1ns/1ns

module tlb_lookup_stage #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  logic                           lookup_i,
  input  logic [19:0]                    vpn_i,
  input  logic                           hit_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0] idx_i,
  input  logic                           multi_hit_i,
  input  logic [NUM_ENTRIES-1:0][5:0]    ps_vec_i,
  input  tlb_pkg::tlb_page_t             page0_i,
  input  tlb_pkg::tlb_page_t             page1_i,
  output logic                           result_valid_o,
  output logic                           hit_o,
  output logic [$clog2(NUM_ENTRIES)-1:0] idx_o,
  output logic [19:0]                    ppn_o,
  output logic                           v_o,
  output logic                           d_o,
  output logic [1:0]                     plv_o,
  output logic                           multi_hit_o
);

  import tlb_pkg::*;

  logic      is_4m;
  logic      odd_sel;
  tlb_page_t page_sel;
  logic [19:0] ppn_d;

  // page size of the hit entry
  assign is_4m = (ps_vec_i[idx_i] == PS_4M);

  // odd half picked by the bit just above the page offset
  assign odd_sel  = is_4m ? vpn_i[10] : vpn_i[0];
  assign page_sel = odd_sel ? page1_i : page0_i;

  // 4 MB page passes va[21:12] straight through
  assign ppn_d = is_4m ? {page_sel.ppn[19:10], vpn_i[9:0]} : page_sel.ppn;

  // control flags, cleared when no lookup
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_valid_o <= 1'b0;
      hit_o          <= 1'b0;
      multi_hit_o    <= 1'b0;
    end else begin
      result_valid_o <= lookup_i;
      hit_o          <= lookup_i && hit_i;
      multi_hit_o    <= lookup_i && multi_hit_i;
    end
  end

  // payload held until the next lookup
  always_ff @(posedge clk) begin
    if (lookup_i) begin
      idx_o <= idx_i;
      ppn_o <= ppn_d;
      // flags meaningless on a miss
      v_o   <= hit_i && page_sel.v;
      d_o   <= hit_i && page_sel.d;
      plv_o <= page_sel.plv;
    end
  end

endmodule

//--- hdl/tlb_top.sv
`timescale 1ns/1ns

module tlb_top #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  // update side
  input  tlb_pkg::tlb_op_e               op_i,
  input  logic [$clog2(NUM_ENTRIES)-1:0] fill_idx_i,
  input  logic [18:0]                    fill_vppn_i,
  input  logic [9:0]                     fill_asid_i,
  input  logic                           fill_g_i,
  input  logic [5:0]                     fill_ps_i,
  input  logic                           fill_e_i,
  input  logic [19:0]                    page0_ppn_i,
  input  logic                           page0_v_i,
  input  logic                           page0_d_i,
  input  logic [1:0]                     page0_plv_i,
  input  logic [19:0]                    page1_ppn_i,
  input  logic                           page1_v_i,
  input  logic                           page1_d_i,
  input  logic [1:0]                     page1_plv_i,
  // lookup side
  input  logic                           lookup_i,
  input  logic [19:0]                    lookup_vpn_i,
  input  logic [9:0]                     lookup_asid_i,
  output logic                           result_valid_o,
  output logic                           hit_o,
  output logic [$clog2(NUM_ENTRIES)-1:0] result_idx_o,
  output logic [19:0]                    ppn_o,
  output logic                           v_o,
  output logic                           d_o,
  output logic [1:0]                     plv_o,
  output logic                           multi_hit_o
);

  import tlb_pkg::*;

  localparam int IDX_W = $clog2(NUM_ENTRIES);

  tlb_key_t  fill_key;
  tlb_page_t fill_page0;
  tlb_page_t fill_page1;

  // controller to array and store
  logic [NUM_ENTRIES-1:0] entry_update;
  tlb_key_t               update_key;
  logic                   page_we;
  logic [IDX_W-1:0]       page_idx;
  tlb_page_t              page0_wr;
  tlb_page_t              page1_wr;

  // array to encoder and lookup stage
  logic [NUM_ENTRIES-1:0]      match_vec;
  logic [NUM_ENTRIES-1:0][5:0] ps_vec;
  logic                        any_hit;
  logic [IDX_W-1:0]            hit_idx;
  logic                        multi;
  tlb_page_t                   page0_rd;
  tlb_page_t                   page1_rd;

  // loose fill ports into structs
  assign fill_key   = '{vppn: fill_vppn_i, asid: fill_asid_i, g: fill_g_i,
                        ps: fill_ps_i, e: fill_e_i};
  assign fill_page0 = '{ppn: page0_ppn_i, v: page0_v_i, d: page0_d_i, plv: page0_plv_i};
  assign fill_page1 = '{ppn: page1_ppn_i, v: page1_v_i, d: page1_d_i, plv: page1_plv_i};

  tlb_ctrl #(.NUM_ENTRIES(NUM_ENTRIES)) ctrl_i (
    .clk(clk), .arst_n_i(arst_n_i), .op_i(op_i), .fill_idx_i(fill_idx_i),
    .fill_key_i(fill_key), .fill_page0_i(fill_page0), .fill_page1_i(fill_page1),
    .entry_update_o(entry_update), .update_key_o(update_key), .page_we_o(page_we),
    .page_idx_o(page_idx), .page0_o(page0_wr), .page1_o(page1_wr)
  );

  // fully associative compare, vpn bit 0 only picks the half
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    tlb_match_entry entry_i (
      .clk(clk), .arst_n_i(arst_n_i), .vppn_i(lookup_vpn_i[19:1]),
      .asid_i(lookup_asid_i), .update_i(entry_update[i]), .update_key_i(update_key),
      .match_o(match_vec[i]), .ps_o(ps_vec[i])
    );
  end

  tlb_hit_encoder #(.NUM_ENTRIES(NUM_ENTRIES)) enc_i (
    .match_vec_i(match_vec), .hit_o(any_hit), .idx_o(hit_idx), .multi_hit_o(multi)
  );

  tlb_page_store #(.NUM_ENTRIES(NUM_ENTRIES)) store_i (
    .clk(clk), .arst_n_i(arst_n_i), .we_i(page_we), .wr_idx_i(page_idx),
    .page0_i(page0_wr), .page1_i(page1_wr), .rd_idx_i(hit_idx),
    .page0_o(page0_rd), .page1_o(page1_rd)
  );

  tlb_lookup_stage #(.NUM_ENTRIES(NUM_ENTRIES)) lookup_stage_i (
    .clk(clk), .arst_n_i(arst_n_i), .lookup_i(lookup_i), .vpn_i(lookup_vpn_i),
    .hit_i(any_hit), .idx_i(hit_idx), .multi_hit_i(multi), .ps_vec_i(ps_vec),
    .page0_i(page0_rd), .page1_i(page1_rd), .result_valid_o(result_valid_o),
    .hit_o(hit_o), .idx_o(result_idx_o), .ppn_o(ppn_o), .v_o(v_o), .d_o(d_o),
    .plv_o(plv_o), .multi_hit_o(multi_hit_o)
  );

endmodule

//--- testbench/tlb_assertions.sv
`timescale 1ns/1ns

module tlb_assertions (
  input logic             clk,
  input logic             arst_n_i,
  input tlb_pkg::tlb_op_e op_i,
  input logic             lookup_i,
  input logic             result_valid_o,
  input logic             hit_o,
  input logic             multi_hit_o
);

  import tlb_pkg::*;

  // count of failed assertions
  int   fail_cnt = 0;
  // set by the first fill after reset
  logic filled_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      filled_q <= 1'b0;
    end else if (op_i == TLB_OP_FILL) begin
      filled_q <= 1'b1;
    end
  end

  // fixed one cycle latency in both directions
  a_valid_after_lookup: assert property (@(posedge clk) disable iff (!arst_n_i)
    lookup_i |=> result_valid_o)
    else begin
      fail_cnt++;
      $error("result_valid_o missing one cycle after lookup_i");
    end
  a_valid_needs_lookup: assert property (@(posedge clk) disable iff (!arst_n_i)
    result_valid_o |-> $past(lookup_i))
    else begin
      fail_cnt++;
      $error("result_valid_o high without a lookup one cycle earlier");
    end
  a_hit_with_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
    hit_o |-> result_valid_o)
    else begin
      fail_cnt++;
      $error("hit_o high while result_valid_o is low");
    end
  // fills never overlap
  a_no_multi_hit: assert property (@(posedge clk) disable iff (!arst_n_i)
    !multi_hit_o)
    else begin
      fail_cnt++;
      $error("multi_hit_o raised");
    end
  a_no_hit_before_fill: assert property (@(posedge clk) disable iff (!arst_n_i)
    !filled_q |-> !hit_o)
    else begin
      fail_cnt++;
      $error("hit reported before any fill");
    end

endmodule

bind tlb_top tlb_assertions asrt_i (
  .clk(clk), .arst_n_i(arst_n_i), .op_i(op_i), .lookup_i(lookup_i),
  .result_valid_o(result_valid_o), .hit_o(hit_o), .multi_hit_o(multi_hit_o)
);

//--- testbench/tb_tlb.sv
`timescale 1ns/1ns

module tb_tlb;

  import tlb_pkg::*;

  localparam int NUM_ENTRIES = 16;
  localparam int IDX_W = $clog2(NUM_ENTRIES);
  // cycles of reset and of every step below
  localparam int STIM_CYCLES = 52;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 20;

  logic clk;
  logic arst_n_i;
  tlb_op_e op_i;
  logic lookup_i;
  logic [19:0] lk_vpn;
  logic [9:0] lk_asid;
  // fill ports driven as structs
  logic [IDX_W-1:0] f_idx;
  tlb_key_t f_key;
  tlb_page_t f_page0;
  tlb_page_t f_page1;
  logic res_valid;
  logic res_hit;
  logic res_v;
  logic res_d;
  logic res_multi;
  logic [IDX_W-1:0] res_idx;
  logic [19:0] res_ppn;
  logic [1:0] res_plv;

  // shadow model
  tlb_key_t m_key [NUM_ENTRIES];
  tlb_page_t m_p0 [NUM_ENTRIES];
  tlb_page_t m_p1 [NUM_ENTRIES];
  logic [19:0] saved_vpn [3];
  logic [9:0] saved_asid [3];
  logic [3:0] t_idx;
  logic [19:0] t_vpn;
  logic [9:0] t_asid;
  logic [31:0] lfsr_q = 32'he9b8;
  int err_cnt = 0;
  int cycle_cnt = 0;

  tlb_top #(.NUM_ENTRIES(NUM_ENTRIES)) dut_i (
    .clk(clk), .arst_n_i(arst_n_i), .op_i(op_i), .fill_idx_i(f_idx),
    .fill_vppn_i(f_key.vppn), .fill_asid_i(f_key.asid), .fill_g_i(f_key.g),
    .fill_ps_i(f_key.ps), .fill_e_i(f_key.e),
    .page0_ppn_i(f_page0.ppn), .page0_v_i(f_page0.v), .page0_d_i(f_page0.d),
    .page0_plv_i(f_page0.plv), .page1_ppn_i(f_page1.ppn), .page1_v_i(f_page1.v),
    .page1_d_i(f_page1.d), .page1_plv_i(f_page1.plv),
    .lookup_i(lookup_i), .lookup_vpn_i(lk_vpn), .lookup_asid_i(lk_asid),
    .result_valid_o(res_valid), .hit_o(res_hit), .result_idx_o(res_idx),
    .ppn_o(res_ppn), .v_o(res_v), .d_o(res_d), .plv_o(res_plv), .multi_hit_o(res_multi)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      val = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // random fill with the index copied into vppn[13:10]
  // so no two entries overlap
  task automatic set_fill(input logic [3:0] idx, input logic g, input logic [5:0] ps);
    f_idx = idx;
    f_key.vppn = {5'(rand_bits(5)), idx, 10'(rand_bits(10))};
    f_key.asid = 10'(rand_bits(10));
    f_key.g = g;
    f_key.ps = ps;
    f_key.e = 1'b1;
    f_page0 = 24'(rand_bits(24));
    f_page1 = 24'(rand_bits(24));
  endtask

  // drive one cycle at the falling edge
  // its lookup is checked at the next one
  task automatic step(input tlb_op_e op, input logic lk, input logic [19:0] vpn,
                      input logic [9:0] asid);
    logic exp_hit;
    logic [IDX_W-1:0] exp_idx;
    logic big;
    tlb_page_t pg;
    logic [19:0] exp_ppn;
    exp_hit = 1'b0;
    exp_idx = '0;
    // model before this cycle's update
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!exp_hit && m_key[i].e && m_key[i].vppn[18:10] == vpn[19:11]
          && (m_key[i].ps == PS_4M || m_key[i].vppn[9:0] == vpn[10:1])
          && (m_key[i].g || m_key[i].asid == asid)) begin
        exp_hit = 1'b1;
        exp_idx = IDX_W'(i);
      end
    end
    big = (m_key[exp_idx].ps == PS_4M);
    pg = (big ? vpn[10] : vpn[0]) ? m_p1[exp_idx] : m_p0[exp_idx];
    exp_ppn = big ? {pg.ppn[19:10], vpn[9:0]} : pg.ppn;
    op_i = op;
    lookup_i = lk;
    lk_vpn = vpn;
    lk_asid = asid;
    if (op == TLB_OP_FILL) begin
      m_key[f_idx] = f_key;
      m_p0[f_idx] = f_page0;
      m_p1[f_idx] = f_page1;
    end else if (op == TLB_OP_INV_ALL) begin
      for (int i = 0; i < NUM_ENTRIES; i++) m_key[i].e = 1'b0;
    end
    @(negedge clk);
    op_i = TLB_OP_NONE;
    lookup_i = 1'b0;
    check_value("result_valid_o", 32'(res_valid), 32'(lk));
    if (lk) begin
      check_value("hit_o", 32'(res_hit), 32'(exp_hit));
      if (exp_hit) begin
        check_value("result_idx_o", 32'(res_idx), 32'(exp_idx));
        check_value("ppn_o", 32'(res_ppn), 32'(exp_ppn));
        check_value("v_o", 32'(res_v), 32'(pg.v));
        check_value("d_o", 32'(res_d), 32'(pg.d));
        check_value("plv_o", 32'(res_plv), 32'(pg.plv));
      end
    end
  endtask

  // watchdog
  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, run stopped after %0d cycles", cycle_cnt);
    $display("sim failed");
    $finish;
  end

  initial begin
    arst_n_i = 1'b0;
    op_i = TLB_OP_NONE;
    lookup_i = 1'b0;
    lk_vpn = '0;
    lk_asid = '0;
    f_idx = '0;
    f_key = '0;
    f_page0 = '0;
    f_page1 = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) m_key[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    // empty after reset
    repeat (4) step(TLB_OP_NONE, 1'b1, 20'(rand_bits(20)), 10'(rand_bits(10)));
    // 4 KB private entry with both halves
    set_fill(4'(rand_bits(4)), 1'b0, 6'd12);
    saved_vpn[0] = {f_key.vppn, 1'b0};
    saved_asid[0] = f_key.asid;
    step(TLB_OP_FILL, 1'b0, '0, '0);
    step(TLB_OP_NONE, 1'b1, saved_vpn[0], saved_asid[0]);
    step(TLB_OP_NONE, 1'b1, saved_vpn[0] | 20'd1, saved_asid[0]);
    // other asid misses
    step(TLB_OP_NONE, 1'b1, saved_vpn[0], saved_asid[0] ^ 10'h1);
    // global entry ignores asid
    set_fill(4'(rand_bits(4)), 1'b1, 6'd12);
    saved_vpn[1] = {f_key.vppn, 1'b1};
    saved_asid[1] = f_key.asid;
    step(TLB_OP_FILL, 1'b0, '0, '0);
    repeat (2) step(TLB_OP_NONE, 1'b1, saved_vpn[1], 10'(rand_bits(10)));
    // 4 MB entry ignores low vppn bits
    set_fill(4'(rand_bits(4)), 1'b0, PS_4M);
    saved_vpn[2] = {f_key.vppn, 1'b0};
    saved_asid[2] = f_key.asid;
    step(TLB_OP_FILL, 1'b0, '0, '0);
    repeat (4) step(TLB_OP_NONE, 1'b1, {f_key.vppn[18:10], 11'(rand_bits(11))}, f_key.asid);
    // flush all and refill
    step(TLB_OP_INV_ALL, 1'b0, '0, '0);
    for (int n = 0; n < 3; n++) step(TLB_OP_NONE, 1'b1, saved_vpn[n], saved_asid[n]);
    set_fill(4'(rand_bits(4)), 1'b0, 6'd12);
    step(TLB_OP_FILL, 1'b0, '0, '0);
    step(TLB_OP_NONE, 1'b1, {f_key.vppn, 1'b1}, f_key.asid);
    // lookup alongside its own fill sees the old entry
    for (int n = 0; n < 8; n++) begin
      set_fill(4'(rand_bits(4)), rand_bits(1) == 1, (rand_bits(1) == 1) ? PS_4M : 6'd12);
      step(TLB_OP_FILL, 1'b1, {f_key.vppn, 1'(rand_bits(1))}, f_key.asid);
    end
    // back to back lookups over the model
    for (int n = 0; n < 16; n++) begin
      t_idx = 4'(rand_bits(4));
      t_vpn = 20'(rand_bits(20));
      t_asid = 10'(rand_bits(10));
      if (m_key[t_idx].e) begin
        t_vpn[19:1] = (m_key[t_idx].ps == PS_4M) ?
                      {m_key[t_idx].vppn[18:10], t_vpn[10:1]} : m_key[t_idx].vppn;
        if (!m_key[t_idx].g) t_asid = m_key[t_idx].asid;
      end
      step(TLB_OP_NONE, 1'b1, t_vpn, t_asid);
    end
    @(negedge clk);
    $display("errors: %0d value, %0d assertion", err_cnt, dut_i.asrt_i.fail_cnt);
    if (err_cnt == 0 && dut_i.asrt_i.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/tlb_pkg.sv
hdl/tlb_match_entry.sv
hdl/tlb_hit_encoder.sv
hdl/tlb_page_store.sv
hdl/tlb_ctrl.sv
hdl/tlb_lookup_stage.sv
hdl/tlb_top.sv
testbench/tlb_assertions.sv
testbench/tb_tlb.sv
